/* Makefile */
# Verilator build and run of the instruction cache testbench

TOP := icache_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing -f sources.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "result: pass"; \
	else \
		echo "result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* icache_ctrl.sv */
`include "icache_params.svh"

module icache_ctrl (
	input  logic                    clk,
	input  logic                    rst,
	input  icache_pkg::fetch_req_t  req,
	input  logic                    advance,
	input  logic                    flush,
	input  icache_pkg::way_mask_t   hit,
	input  icache_pkg::line_t       refill_line,
	input  icache_pkg::line_t       way_dout [`ICACHE_WAYS],
	output icache_pkg::way_mask_t   fill,
	output icache_pkg::way_mask_t   way_en,
	output logic                    way_wr,
	output icache_pkg::index_t      way_index,
	output icache_pkg::line_t       way_din,
	output icache_pkg::refill_req_t refill_req,
	output icache_pkg::fetch_rsp_t  rsp
);
	import icache_pkg::*;

	logic        accept;
	logic        miss;
	way_mask_t   rot_q;
	way_mask_t   hit_q;
	addr_t       pc_q;
	line_t       line_q;
	logic        ready_q;
	line_t       line_sel;
	inst_t       inst_live;
	inst_t       inst_hold;
	hold_state_e hold_state;

	assign accept = req.valid && advance;
	assign miss   = accept && (hit == '0);

	// hit way is read, on a miss the rotator's way is written
	always_comb begin
		if (!accept) begin
			way_en = '0;
		end else if (miss) begin
			way_en = rot_q;
		end else begin
			way_en = hit;
		end
	end

	assign way_wr    = miss;
	assign way_index = req.pc[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
	assign way_din   = refill_line;
	assign fill      = miss ? rot_q : '0;

	// memory answers combinationally in the miss cycle
	assign refill_req.valid = miss;
	assign refill_req.addr  = req.pc;

	// pipeline state, frozen while the next stage stalls
	always_ff @(posedge clk) begin
		if (rst) begin
			rot_q   <= way_mask_t'(1);
			hit_q   <= '0;
			line_q  <= '0;
			ready_q <= 1'b0;
		end else if (advance) begin
			if (flush) begin
				// drop the response in flight, rotator stays put
				hit_q   <= '0;
				line_q  <= '0;
				ready_q <= 1'b0;
			end else begin
				rot_q   <= {rot_q[`ICACHE_WAYS-2:0], rot_q[`ICACHE_WAYS-1]};
				hit_q   <= req.valid ? hit : '0;
				line_q  <= refill_line;
				ready_q <= req.valid;
			end
		end
	end

	// word offset of the response
	always_ff @(posedge clk) begin
		if (advance) begin
			pc_q <= req.pc;
		end
	end

	// hit way's SRAM output, else the line that came from memory
	always_comb begin
		line_sel = line_q;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (hit_q[w]) begin
				line_sel = way_dout[w];
			end
		end
	end

	assign inst_live = line_sel[pc_q[`ICACHE_OFFSET_W-1:2] * `ICACHE_INST_W +: `ICACHE_INST_W];

	// enter hold on the first stalled edge, leave when advance returns
	always_ff @(posedge clk) begin
		if (rst) begin
			hold_state <= HOLD_PASS;
		end else begin
			case (hold_state)
				HOLD_PASS: begin
					if (!advance) begin
						hold_state <= HOLD_KEEP;
					end
				end
				HOLD_KEEP: begin
					if (advance) begin
						hold_state <= HOLD_PASS;
					end
				end
				default: begin
					hold_state <= HOLD_PASS;
				end
			endcase
		end
	end

	// captured once, in the first cycle with advance low
	always_ff @(posedge clk) begin
		if (hold_state == HOLD_PASS && !advance) begin
			inst_hold <= inst_live;
		end
	end

	assign rsp.ready = ready_q;
	assign rsp.inst  = (hold_state == HOLD_KEEP) ? inst_hold : inst_live;

endmodule

/* icache_params.svh */
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// fetch address width of the core
`define ICACHE_ADDR_W 64

// one cache line holds four instructions
`define ICACHE_LINE_W 128
`define ICACHE_INST_W 32
`define ICACHE_OFFSET_W 4

// set geometry
`define ICACHE_INDEX_W 6
`define ICACHE_SETS (1 << `ICACHE_INDEX_W)

// whatever is left of the address above index and offset
`define ICACHE_TAG_W (`ICACHE_ADDR_W - `ICACHE_INDEX_W - `ICACHE_OFFSET_W)

// fixed, the replacement rotator is one-hot over four ways
`define ICACHE_WAYS 4

`endif

/* icache_pkg.sv */
`include "icache_params.svh"

package icache_pkg;

	// plain vectors with a meaning
	typedef logic [`ICACHE_ADDR_W-1:0] addr_t;
	typedef logic [`ICACHE_LINE_W-1:0] line_t;
	typedef logic [`ICACHE_INST_W-1:0] inst_t;
	typedef logic [`ICACHE_TAG_W-1:0] tag_t;
	typedef logic [`ICACHE_INDEX_W-1:0] index_t;

	// one-hot or zero, bit n is way n
	typedef logic [`ICACHE_WAYS-1:0] way_mask_t;

	// fetch request from the IF stage
	typedef struct packed {
		logic valid;
		addr_t pc;
	} fetch_req_t;

	// response back to fetch, ready marks a valid inst
	typedef struct packed {
		logic ready;
		inst_t inst;
	} fetch_rsp_t;

	// line request to memory, answered in the same cycle
	typedef struct packed {
		logic valid;
		addr_t addr;
	} refill_req_t;

	// output hold while the next stage stalls
	typedef enum logic {
		HOLD_PASS,
		HOLD_KEEP
	} hold_state_e;

endpackage

/* icache_tag_array.sv */
`include "icache_params.svh"

module icache_tag_array (
	input  logic                  clk,
	input  logic                  rst,
	input  icache_pkg::addr_t     pc,
	input  icache_pkg::way_mask_t fill,
	output icache_pkg::way_mask_t hit
);
	import icache_pkg::*;

	index_t index;
	tag_t   tag;

	// address split
	assign index = pc[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
	assign tag   = pc[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];

	// one tag store and one valid vector per way
	for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
		logic [`ICACHE_SETS-1:0] valid_q;
		tag_t                    tag_mem [`ICACHE_SETS];
		logic                    valid_rd;
		tag_t                    tag_rd;

		// valid bits are the only state that needs clearing
		always_ff @(posedge clk) begin
			if (rst) begin
				valid_q <= '0;
			end else if (fill[w]) begin
				valid_q[index] <= 1'b1;
			end
		end

		// tag written together with the line on a miss
		always_ff @(posedge clk) begin
			if (fill[w]) begin
				tag_mem[index] <= tag;
			end
		end

		// lookup sees the state before this cycle's fill
		assign valid_rd = valid_q[index];
		assign tag_rd   = tag_mem[index];
		assign hit[w]   = valid_rd && (tag_rd == tag);
	end

endmodule

/* icache_tb.sv */
`include "icache_params.svh"

module icache_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import icache_pkg::*;

	// cycles per test, reset included, then doubled for the limit
	localparam int CYCLE_BUDGET   = 6 + 3 + 3 + 16 + 9 + 7 + 4;
	localparam int TIMEOUT_CYCLES = 2 * CYCLE_BUDGET;
	localparam logic [31:0] MEM_XOR = 32'hA5C3_0F69;

	logic        clk = 1'b0;
	logic        rst;
	fetch_req_t  req;
	logic        advance;
	logic        flush;
	fetch_rsp_t  rsp;
	refill_req_t refill_req;
	line_t       refill_line;

	// reference state
	logic        mvalid [`ICACHE_SETS][`ICACHE_WAYS];
	tag_t        mtag [`ICACHE_SETS][`ICACHE_WAYS];
	way_mask_t   mrot;
	logic        exp_ready;
	inst_t       exp_inst;

	logic [31:0] lcg_state = 32'd94296;
	int          cycle_count = 0;
	int          checks = 0;
	int          errors = 0;
	int          tests_run = 0;

	icache_top DUT (
		.clk         (clk),
		.rst         (rst),
		.req         (req),
		.advance     (advance),
		.flush       (flush),
		.rsp         (rsp),
		.refill_req  (refill_req),
		.refill_line (refill_line)
	);

	always #2 clk = ~clk;

	// word w of a line: address with the word offset put in, then scrambled
	function automatic inst_t mem_word(input addr_t a, input logic [1:0] w);
		logic [31:0] v;
		v = a[31:0];
		v[3:0] = {w, 2'b00};
		return v ^ MEM_XOR;
	endfunction

	// backing memory answers in the same cycle
	assign refill_line = {mem_word(refill_req.addr, 2'd3), mem_word(refill_req.addr, 2'd2),
		mem_word(refill_req.addr, 2'd1), mem_word(refill_req.addr, 2'd0)};

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("run timed out after %0d cycles without finishing the tests", cycle_count);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	function logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// line aligned, tag kept in the low half of the address
	function addr_t random_line();
		logic [31:0] r;
		r = lcg_next();
		return {32'h0, r[31:4], 4'h0};
	endfunction

	function automatic way_mask_t model_hit(input addr_t pc);
		index_t    idx;
		tag_t      tg;
		way_mask_t m;
		idx = pc[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
		tg  = pc[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			m[w] = mvalid[idx][w] && (mtag[idx][w] == tg);
		end
		return m;
	endfunction

	task automatic check_inst(input string name, input inst_t got, input inst_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		$display("test %-16s %s, %0d errors", name,
			(errors == errors_before) ? "ok" : "failed", errors - errors_before);
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		req = '0;
		advance = 1'b0;
		flush = 1'b0;
		for (int s = 0; s < `ICACHE_SETS; s++) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				mvalid[s][w] = 1'b0;
				mtag[s][w] = '0;
			end
		end
		mrot = 4'b0001;
		exp_ready = 1'b0;
		exp_inst = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	endtask

	// one clock: drive, check refill, update the model, check the response
	task automatic run_cycle(input logic valid, input addr_t pc, input logic adv,
		input logic flsh, output logic missed);
		index_t idx;
		tag_t   tg;
		logic   exp_miss;
		idx = pc[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
		tg  = pc[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
		@(negedge clk);
		req.valid = valid;
		req.pc = pc;
		advance = adv;
		flush = flsh;
		exp_miss = valid && adv && (model_hit(pc) == '0);
		#1;
		check_bit("refill_req.valid", refill_req.valid, exp_miss);
		if (exp_miss) begin
			check_addr("refill_req.addr", refill_req.addr, pc);
		end
		missed = refill_req.valid;
		@(posedge clk);
		// miss fills the rotator's way, even under flush
		if (exp_miss) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				if (mrot[w]) begin
					mvalid[idx][w] = 1'b1;
					mtag[idx][w] = tg;
				end
			end
		end
		if (adv && !flsh) begin
			mrot = {mrot[2:0], mrot[3]};
			exp_ready = valid;
			exp_inst = mem_word(pc, pc[3:2]);
		end else if (adv) begin
			exp_ready = 1'b0;
		end
		#1;
		check_bit("rsp.ready", rsp.ready, exp_ready);
		if (exp_ready) begin
			check_inst("rsp.inst", rsp.inst, exp_inst);
		end
	endtask

	task automatic test_reset_state();
		int   start;
		logic m;
		start = errors;
		#1;
		check_bit("rsp.ready", rsp.ready, 1'b0);
		check_bit("refill_req.valid", refill_req.valid, 1'b0);
		run_cycle(1'b0, '0, 1'b1, 1'b0, m);
		run_cycle(1'b0, '0, 1'b1, 1'b0, m);
		report_test("reset_state", start);
	endtask

	task automatic test_miss_then_hit();
		int    start;
		logic  m;
		addr_t a;
		start = errors;
		a = random_line();
		run_cycle(1'b1, a + 64'd4, 1'b1, 1'b0, m);
		check_bit("cold fetch refill", m, 1'b1);
		run_cycle(1'b1, a + 64'd12, 1'b1, 1'b0, m);
		check_bit("warm fetch refill", m, 1'b0);
		report_test("miss_then_hit", start);
	endtask

	task automatic test_word_select();
		int    start;
		logic  m;
		addr_t a;
		start = errors;
		for (int n = 0; n < 4; n++) begin
			a = random_line();
			for (int off = 0; off < 4; off++) begin
				run_cycle(1'b1, a + addr_t'(off * 4), 1'b1, 1'b0, m);
			end
		end
		report_test("word_select", start);
	endtask

	// five tags in one set, fills walk the rotator
	task automatic test_replacement();
		int        start;
		int        evicted;
		logic      m;
		index_t    idx;
		addr_t     lines [5];
		way_mask_t way_of [5];
		start = errors;
		evicted = 0;
		idx = index_t'(lcg_next() >> 8);
		for (int k = 0; k < 5; k++) begin
			lines[k] = '0;
			lines[k][`ICACHE_ADDR_W-1] = 1'b1;
			lines[k][`ICACHE_OFFSET_W + `ICACHE_INDEX_W +: 8] = 8'(k + 1);
			lines[k][`ICACHE_OFFSET_W +: `ICACHE_INDEX_W] = idx;
		end
		for (int k = 0; k < 5; k++) begin
			way_of[k] = mrot;
			run_cycle(1'b1, lines[k], 1'b1, 1'b0, m);
			check_bit("new tag refill", m, 1'b1);
			// an idle advancing cycle still moves the rotator
			if (k == 1) begin
				run_cycle(1'b0, '0, 1'b1, 1'b0, m);
			end
		end
		for (int k = 0; k < 4; k++) begin
			if (way_of[k] == way_of[4]) begin
				evicted = k;
			end
		end
		run_cycle(1'b1, lines[evicted] + 64'd8, 1'b1, 1'b0, m);
		check_bit("evicted line refill", m, 1'b1);
		run_cycle(1'b1, lines[4] + 64'd4, 1'b1, 1'b0, m);
		check_bit("surviving line refill", m, 1'b0);
		report_test("replacement", start);
	endtask

	task automatic test_stall_hold();
		int    start;
		logic  m;
		addr_t a;
		inst_t held;
		start = errors;
		a = random_line() + 64'd8;
		held = mem_word(a, a[3:2]);
		run_cycle(1'b1, a, 1'b1, 1'b0, m);
		// request stays up but is not accepted
		repeat (4) begin
			run_cycle(1'b1, random_line(), 1'b0, 1'b0, m);
			check_inst("held rsp.inst", rsp.inst, held);
			check_bit("held rsp.ready", rsp.ready, 1'b1);
		end
		a = random_line() + 64'd12;
		run_cycle(1'b1, a, 1'b1, 1'b0, m);
		report_test("stall_hold", start);
	endtask

	task automatic test_flush_cancel();
		int    start;
		logic  m;
		addr_t a;
		start = errors;
		a = random_line() + 64'd4;
		run_cycle(1'b1, a, 1'b1, 1'b1, m);
		check_bit("rsp.ready after flush", rsp.ready, 1'b0);
		run_cycle(1'b1, random_line() + 64'd12, 1'b1, 1'b0, m);
		run_cycle(1'b1, a, 1'b1, 1'b0, m);
		report_test("flush_cancel", start);
	endtask

	initial begin
		apply_reset();
		test_reset_state();
		test_miss_then_hit();
		test_word_select();
		test_replacement();
		test_stall_hold();
		test_flush_cancel();
		$display("tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

/* icache_top.sv */
`include "icache_params.svh"

module icache_top (
	input  logic                    clk,
	input  logic                    rst,
	input  icache_pkg::fetch_req_t  req,
	input  logic                    advance,
	input  logic                    flush,
	output icache_pkg::fetch_rsp_t  rsp,
	output icache_pkg::refill_req_t refill_req,
	input  icache_pkg::line_t       refill_line
);
	import icache_pkg::*;

	way_mask_t hit;
	way_mask_t fill;
	way_mask_t way_en;
	logic      way_wr;
	index_t    way_index;
	line_t     way_din;
	line_t     way_dout [`ICACHE_WAYS];

	icache_tag_array u_tag_array (
		.clk  (clk),
		.rst  (rst),
		.pc   (req.pc),
		.fill (fill),
		.hit  (hit)
	);

	icache_ctrl u_ctrl (
		.clk         (clk),
		.rst         (rst),
		.req         (req),
		.advance     (advance),
		.flush       (flush),
		.hit         (hit),
		.refill_line (refill_line),
		.way_dout    (way_dout),
		.fill        (fill),
		.way_en      (way_en),
		.way_wr      (way_wr),
		.way_index   (way_index),
		.way_din     (way_din),
		.refill_req  (refill_req),
		.rsp         (rsp)
	);

	// one line store per way, sharing index and write data
	icache_way_sram way0 (
		.clk   (clk),
		.en    (way_en[0]),
		.wr    (way_wr),
		.index (way_index),
		.din   (way_din),
		.dout  (way_dout[0])
	);

	icache_way_sram way1 (
		.clk   (clk),
		.en    (way_en[1]),
		.wr    (way_wr),
		.index (way_index),
		.din   (way_din),
		.dout  (way_dout[1])
	);

	icache_way_sram way2 (
		.clk   (clk),
		.en    (way_en[2]),
		.wr    (way_wr),
		.index (way_index),
		.din   (way_din),
		.dout  (way_dout[2])
	);

	icache_way_sram way3 (
		.clk   (clk),
		.en    (way_en[3]),
		.wr    (way_wr),
		.index (way_index),
		.din   (way_din),
		.dout  (way_dout[3])
	);

endmodule

/* icache_way_sram.sv */
`include "icache_params.svh"

module icache_way_sram (
	input  logic               clk,
	input  logic               en,
	input  logic               wr,
	input  icache_pkg::index_t index,
	input  icache_pkg::line_t  din,
	output icache_pkg::line_t  dout
);
	import icache_pkg::*;

	// one line per set
	line_t mem [`ICACHE_SETS];

	// single port, write or read when enabled
	always_ff @(posedge clk) begin
		if (en) begin
			if (wr) begin
				mem[index] <= din;
			end else begin
				dout <= mem[index];
			end
		end
	end

endmodule

/* sources.f */
+incdir+.
icache_pkg.sv
icache_tag_array.sv
icache_way_sram.sv
icache_ctrl.sv
icache_top.sv
icache_tb.sv
